/* all.f */
mcu_pkg.sv
st_cfg_capture.sv
st_lane_writer.sv
st_data_buffer.sv
st_stream_writer.sv
store_ctrl_top.sv
tb_axi_sink.sv
tb_store_ctrl.sv

/* run.sh */
#!/bin/sh
# Compile and run the store unit testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_store_ctrl -f all.f -o tb_store_ctrl
./obj_dir/tb_store_ctrl > sim.log
cat sim.log
if grep -q "sim failed" sim.log; then
  exit 1
fi
grep -q "sim passed" sim.log

/* tb_store_ctrl.sv */
// Testbench top for the vector store control unit
// Clock, reset, lane driver, configuration stimulus and checks
`timescale 1ns/1ps

module tb_store_ctrl
  import mcu_pkg::*;
();

  localparam int TIMEOUT = 2000;

  logic     clk;
  logic     rstn;
  sew_t     cfg_sew_i;
  sew_t     cfg_eew_i;
  lmul_t    cfg_lmul_i;
  st_mode_t cfg_mode_i;
  addr_t    cfg_base_i;
  stride_t  cfg_stride_i;
  vl_t      cfg_vl_i;
  logic     cfg_vld_i;
  logic     cfg_rdy_o;
  logic     cfg_err_o;
  lmul_t    cfg_emul_o;
  data_t    lane_data_i;
  logic     lane_vld_i;
  logic     lane_rdy_o;
  logic     wr_start_o;
  addr_t    wr_addr_o;
  vl_t      wr_len_o;
  data_t    wr_data_o;
  logic     wr_tvalid_o;
  logic     wr_tready_i;
  logic     wr_tlast_o;
  logic     wr_done_i;
  logic     st_done_o;
  logic     bp_stall;

  integer seed = 53020;
  int     errors;
  int     tests_pass;
  int     tests_fail;
  data_t  lane_q [$];
  int     gap_q [$];
  data_t  exp_q [$];

  store_ctrl_top i_store_ctrl_top (
    .clk          (clk),
    .rstn         (rstn),
    .cfg_sew_i    (cfg_sew_i),
    .cfg_eew_i    (cfg_eew_i),
    .cfg_lmul_i   (cfg_lmul_i),
    .cfg_mode_i   (cfg_mode_i),
    .cfg_base_i   (cfg_base_i),
    .cfg_stride_i (cfg_stride_i),
    .cfg_vl_i     (cfg_vl_i),
    .cfg_vld_i    (cfg_vld_i),
    .cfg_rdy_o    (cfg_rdy_o),
    .cfg_err_o    (cfg_err_o),
    .cfg_emul_o   (cfg_emul_o),
    .lane_data_i  (lane_data_i),
    .lane_vld_i   (lane_vld_i),
    .lane_rdy_o   (lane_rdy_o),
    .wr_start_o   (wr_start_o),
    .wr_addr_o    (wr_addr_o),
    .wr_len_o     (wr_len_o),
    .wr_data_o    (wr_data_o),
    .wr_tvalid_o  (wr_tvalid_o),
    .wr_tready_i  (wr_tready_i),
    .wr_tlast_o   (wr_tlast_o),
    .wr_done_i    (wr_done_i),
    .st_done_o    (st_done_o)
  );

  tb_axi_sink i_tb_axi_sink (
    .clk         (clk),
    .rstn        (rstn),
    .stall_i     (bp_stall),
    .wr_start_i  (wr_start_o),
    .wr_addr_i   (wr_addr_o),
    .wr_len_i    (wr_len_o),
    .wr_tvalid_i (wr_tvalid_o),
    .wr_tlast_i  (wr_tlast_o),
    .wr_tready_o (wr_tready_i),
    .wr_done_o   (wr_done_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////
  // Lane driver
  ////////////////////

  initial begin
    logic lane_taken;
    lane_vld_i  = 1'b0;
    lane_data_i = '0;
    forever begin
      @(negedge clk);
      lane_taken = lane_vld_i && lane_rdy_o;
      @(posedge clk);
      #1;
      if (lane_taken) begin
        void'(lane_q.pop_front());
        lane_vld_i = 1'b0;
      end
      // Each element waits out its own random gap first
      if (!lane_vld_i && (lane_q.size() > 0)) begin
        if (gap_q[0] > 0) begin
          gap_q[0] = gap_q[0] - 1;
        end else begin
          void'(gap_q.pop_front());
          lane_vld_i  = 1'b1;
          lane_data_i = lane_q[0];
        end
      end
    end
  end

  ////////////////////
  // Check helpers
  ////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    assert (got === expected) else begin
      $display("** Error %s: got 0x%h, expected 0x%h", name, got, expected);
      errors++;
    end
  endtask

  // EMUL from the log2 rule, fractional LMUL codes count below zero
  function automatic void expected_emul(input lmul_t lmul, input sew_t sew, input sew_t eew,
                                        output logic ok, output logic [2:0] code);
    int l;
    int e;
    case (lmul)
      3'd5: l = -3;
      3'd6: l = -2;
      3'd7: l = -1;
      default: l = int'(lmul);
    endcase
    e    = l + int'(eew) - int'(sew);
    ok   = (lmul != 3'd4) && (sew != 3'd3) && (eew != 3'd3) && (e >= -3) && (e <= 3);
    code = 3'((e < 0) ? e + 8 : e);
  endfunction

  task automatic end_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_pass++;
      $display("test %s: ok", name);
    end else begin
      tests_fail++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////
  // One store transfer
  ////////////////////

  task automatic run_store(input st_mode_t mode, input sew_t sew, input sew_t eew,
                           input lmul_t lmul, input addr_t base, input stride_t stride,
                           input vl_t vl, input logic stall);
    logic       emul_ok;
    logic [2:0] emul_code;
    logic       cfg_ok;
    logic       finished;
    logic       prev_stall;
    logic       prev_done;
    logic       prev_last;
    logic       exp_last;
    data_t      prev_data;
    data_t      d;
    addr_t      exp_addr;
    int         n;
    int         k;
    int         bursts;
    int         beats;
    int         taken;
    int         dones;
    int         cmd_base;
    int         ncmd;
    expected_emul(lmul, sew, eew, emul_ok, emul_code);
    cfg_ok = emul_ok && (vl != '0) && (int'(vl) <= MAX_VL);
    bursts = (mode == ST_UNIT) ? 1 : int'(vl);
    @(negedge clk);
    bp_stall = stall;
    cmd_base = i_tb_axi_sink.cmd_cnt;
    if (cfg_ok) begin
      for (k = 0; k < int'(vl); k++) begin
        d = $random(seed);
        lane_q.push_back(d);
        exp_q.push_back(d);
        gap_q.push_back($random(seed) & 3);
      end
    end
    @(posedge clk);
    #1;
    cfg_sew_i    = sew;
    cfg_eew_i    = eew;
    cfg_lmul_i   = lmul;
    cfg_mode_i   = mode;
    cfg_base_i   = base;
    cfg_stride_i = stride;
    cfg_vl_i     = vl;
    cfg_vld_i    = 1'b1;
    n = 0;
    @(negedge clk);
    while (!cfg_rdy_o && (n < TIMEOUT)) begin
      @(negedge clk);
      n++;
    end
    assert (cfg_rdy_o) else begin
      $display("Timeout while waiting for the configuration to be accepted");
      errors++;
    end
    @(posedge clk);
    #1;
    cfg_vld_i = 1'b0;
    // First cycle after acceptance
    @(negedge clk);
    if (emul_ok) begin
      check_value("cfg_emul_o", 32'(cfg_emul_o), 32'(emul_code));
    end
    check_value("cfg_err_o", 32'(cfg_err_o), 32'(!cfg_ok));
    check_value("wr_start_o", 32'(wr_start_o), 0);
    @(negedge clk);
    if (!cfg_ok) begin
      check_value("cfg_rdy_o", 32'(cfg_rdy_o), 1);
      for (k = 0; k < 4; k++) begin
        check_value("cfg_err_o", 32'(cfg_err_o), 0);
        check_value("wr_start_o", 32'(wr_start_o), 0);
        check_value("lane_rdy_o", 32'(lane_rdy_o), 0);
        @(negedge clk);
      end
    end else begin
      check_value("wr_start_o", 32'(wr_start_o), 1);
      n          = 0;
      beats      = 0;
      // The lane may already hand over its first element in this cycle
      taken      = (lane_vld_i && lane_rdy_o) ? 1 : 0;
      dones      = 0;
      finished   = 1'b0;
      prev_stall = 1'b0;
      prev_done  = 1'b0;
      prev_last  = 1'b0;
      prev_data  = '0;
      while (!finished && (n < TIMEOUT)) begin
        @(negedge clk);
        n++;
        // A stalled beat keeps valid, data and last
        if (prev_stall) begin
          check_value("wr_tvalid_o", 32'(wr_tvalid_o), 1);
          check_value("wr_data_o", wr_data_o, prev_data);
          check_value("wr_tlast_o", 32'(wr_tlast_o), 32'(prev_last));
        end
        if (wr_tvalid_o && wr_tready_i) begin
          exp_last = (mode == ST_STRIDED) || (beats == int'(vl) - 1);
          check_value("wr_tlast_o", 32'(wr_tlast_o), 32'(exp_last));
          assert (exp_q.size() > 0) else begin
            $display("Stream beat arrived with no lane element left to send");
            errors++;
          end
          if (exp_q.size() > 0) begin
            d = exp_q.pop_front();
            check_value("wr_data_o", wr_data_o, d);
          end
          beats++;
        end
        prev_stall = wr_tvalid_o && !wr_tready_i;
        prev_data  = wr_data_o;
        prev_last  = wr_tlast_o;
        // Whole vector fits, so the lane is only held off once all of it is in
        if (taken == int'(vl)) begin
          check_value("lane_rdy_o", 32'(lane_rdy_o), 0);
        end else if (bp_stall) begin
          check_value("lane_rdy_o", 32'(lane_rdy_o), 1);
        end
        if (lane_vld_i && lane_rdy_o) begin
          taken++;
        end
        if (bp_stall && (taken == int'(vl))) begin
          bp_stall = 1'b0;
        end
        check_value("st_done_o", 32'(st_done_o), 32'(prev_done && (dones == bursts)));
        if (st_done_o) begin
          check_value("cfg_rdy_o", 32'(cfg_rdy_o), 1);
          finished = 1'b1;
        end else begin
          check_value("cfg_rdy_o", 32'(cfg_rdy_o), 0);
        end
        if (wr_done_i) begin
          dones++;
        end
        prev_done = wr_done_i;
      end
      assert (finished) else begin
        $display("Timeout while waiting for the store to complete");
        errors++;
        exp_q.delete();
        lane_q.delete();
        gap_q.delete();
      end
      bp_stall = 1'b0;
      check_value("wr_tvalid_o beats", beats, 32'(vl));
      ncmd = i_tb_axi_sink.cmd_cnt - cmd_base;
      check_value("wr_start_o count", ncmd, bursts);
      for (k = 0; (k < ncmd) && (k < bursts); k++) begin
        exp_addr = (mode == ST_STRIDED) ? base + stride * 32'(k) : base;
        check_value("wr_addr_o", i_tb_axi_sink.cmd_addr[cmd_base + k], exp_addr);
        check_value("wr_len_o", 32'(i_tb_axi_sink.cmd_len[cmd_base + k]),
                    (mode == ST_UNIT) ? 32'(vl) : 1);
      end
    end
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int       errs;
    int       k;
    addr_t    base_r;
    stride_t  stride_r;
    vl_t      vl_r;
    st_mode_t mode_r;
    errors       = 0;
    tests_pass   = 0;
    tests_fail   = 0;
    rstn         = 1'b0;
    bp_stall     = 1'b0;
    cfg_sew_i    = '0;
    cfg_eew_i    = '0;
    cfg_lmul_i   = '0;
    cfg_mode_i   = ST_UNIT;
    cfg_base_i   = '0;
    cfg_stride_i = '0;
    cfg_vl_i     = '0;
    cfg_vld_i    = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b1;

    // Reset state and EMUL results of legal settings
    errs = errors;
    @(negedge clk);
    check_value("cfg_rdy_o", 32'(cfg_rdy_o), 1);
    check_value("lane_rdy_o", 32'(lane_rdy_o), 0);
    check_value("cfg_err_o", 32'(cfg_err_o), 0);
    check_value("wr_start_o", 32'(wr_start_o), 0);
    check_value("wr_tvalid_o", 32'(wr_tvalid_o), 0);
    check_value("st_done_o", 32'(st_done_o), 0);
    run_store(ST_UNIT, 3'd2, 3'd2, 3'd0, 32'h0000_1000, '0, vl_t'(1 + ($random(seed) & 3)), 1'b0);
    run_store(ST_UNIT, 3'd0, 3'd2, 3'd1, 32'h0000_2000, '0, vl_t'(1 + ($random(seed) & 3)), 1'b0);
    run_store(ST_UNIT, 3'd2, 3'd0, 3'd0, 32'h0000_3000, '0, vl_t'(1 + ($random(seed) & 3)), 1'b0);
    run_store(ST_UNIT, 3'd1, 3'd2, 3'd7, 32'h0000_4000, '0, vl_t'(1 + ($random(seed) & 3)), 1'b0);
    run_store(ST_UNIT, 3'd0, 3'd1, 3'd5, 32'h0000_5000, '0, vl_t'(1 + ($random(seed) & 3)), 1'b0);
    run_store(ST_UNIT, 3'd2, 3'd1, 3'd2, 32'h0000_6000, '0, vl_t'(1 + ($random(seed) & 3)), 1'b0);
    end_test("reset and emul", errs);

    // Illegal configurations
    errs = errors;
    run_store(ST_UNIT, 3'd2, 3'd2, 3'd4, 32'h0000_1000, '0, vl_t'(4), 1'b0);
    run_store(ST_UNIT, 3'd3, 3'd2, 3'd0, 32'h0000_1000, '0, vl_t'(4), 1'b0);
    run_store(ST_UNIT, 3'd2, 3'd3, 3'd0, 32'h0000_1000, '0, vl_t'(4), 1'b0);
    run_store(ST_UNIT, 3'd0, 3'd2, 3'd3, 32'h0000_1000, '0, vl_t'(4), 1'b0);
    run_store(ST_UNIT, 3'd2, 3'd0, 3'd6, 32'h0000_1000, '0, vl_t'(4), 1'b0);
    run_store(ST_UNIT, 3'd2, 3'd2, 3'd0, 32'h0000_1000, '0, vl_t'(0), 1'b0);
    run_store(ST_UNIT, 3'd2, 3'd2, 3'd0, 32'h0000_1000, '0, vl_t'(MAX_VL + 1), 1'b0);
    end_test("illegal configurations", errs);

    // Unit-stride bursts
    errs = errors;
    for (k = 0; k < 4; k++) begin
      base_r = addr_t'($random(seed)) & 32'hFFFF_FFFC;
      vl_r   = vl_t'(1 + ($random(seed) & 15));
      run_store(ST_UNIT, 3'd2, 3'd2, 3'd0, base_r, '0, vl_r, 1'b0);
    end
    end_test("unit-stride", errs);

    // Strided single-beat bursts
    errs = errors;
    for (k = 0; k < 4; k++) begin
      base_r   = addr_t'($random(seed)) & 32'hFFFF_FFFC;
      stride_r = stride_t'($random(seed)) & 32'h0000_03FC;
      vl_r     = vl_t'(1 + ($random(seed) & 15));
      run_store(ST_STRIDED, 3'd2, 3'd2, 3'd0, base_r, stride_r, vl_r, 1'b0);
    end
    end_test("strided", errs);

    // Back-pressure, full buffer, then random traffic in either mode
    errs = errors;
    run_store(ST_UNIT, 3'd2, 3'd2, 3'd0, 32'h0001_0000, '0, vl_t'(MAX_VL), 1'b1);
    run_store(ST_STRIDED, 3'd2, 3'd2, 3'd0, 32'h0002_0000, 32'h0000_0040,
              vl_t'(1 + ($random(seed) & 15)), 1'b1);
    for (k = 0; k < 4; k++) begin
      mode_r   = (($random(seed) & 1) != 0) ? ST_STRIDED : ST_UNIT;
      base_r   = addr_t'($random(seed)) & 32'hFFFF_FFFC;
      stride_r = stride_t'($random(seed)) & 32'h0000_00FC;
      vl_r     = vl_t'(1 + ($random(seed) & 15));
      run_store(mode_r, 3'd2, 3'd2, 3'd0, base_r, stride_r, vl_r, 1'b0);
    end
    end_test("back-pressure", errs);

    $display("tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
    if ((errors == 0) && (tests_fail == 0)) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* tb_axi_sink.sv */
// Memory write side model for the store unit testbench
// Random back-pressure, burst command log, delayed burst completion
`timescale 1ns/1ps

module tb_axi_sink
  import mcu_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  input  logic  stall_i,
  input  logic  wr_start_i,
  input  addr_t wr_addr_i,
  input  vl_t   wr_len_i,
  input  logic  wr_tvalid_i,
  input  logic  wr_tlast_i,
  output logic  wr_tready_o,
  output logic  wr_done_o
);

  localparam int CMD_MAX = 256;

  // Command log read by the testbench top
  addr_t  cmd_addr [CMD_MAX];
  vl_t    cmd_len  [CMD_MAX];
  int     cmd_cnt;
  int     done_wait;
  logic   last_hs;
  integer seed = 53020;

  initial begin
    wr_tready_o = 1'b0;
    wr_done_o   = 1'b0;
    cmd_cnt     = 0;
    done_wait   = 0;
    forever begin
      // Outputs of the DUT are stable at the falling edge
      @(negedge clk);
      last_hs = wr_tvalid_i && wr_tready_o && wr_tlast_i;
      if (wr_start_i && (cmd_cnt < CMD_MAX)) begin
        cmd_addr[cmd_cnt] = wr_addr_i;
        cmd_len[cmd_cnt]  = wr_len_i;
        cmd_cnt++;
      end
      @(posedge clk);
      #1;
      wr_done_o = 1'b0;
      if (!rstn) begin
        wr_tready_o = 1'b0;
        done_wait   = 0;
      end else begin
        // Completion one to four cycles after the last beat
        if (last_hs) begin
          done_wait = 1 + ($random(seed) & 3);
        end
        if (done_wait > 0) begin
          done_wait--;
          if (done_wait == 0) begin
            wr_done_o = 1'b1;
          end
        end
        wr_tready_o = stall_i ? 1'b0 : (($random(seed) & 3) != 0);
      end
    end
  end

endmodule

/* store_ctrl_top.sv */
// Top level of the vector store control unit
// Configuration stage, lane writer, store buffer and stream sequencer
`timescale 1ns/1ps

module store_ctrl_top
  import mcu_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  // Scheduler configuration
  input  sew_t     cfg_sew_i,
  input  sew_t     cfg_eew_i,
  input  lmul_t    cfg_lmul_i,
  input  st_mode_t cfg_mode_i,
  input  addr_t    cfg_base_i,
  input  stride_t  cfg_stride_i,
  input  vl_t      cfg_vl_i,
  input  logic     cfg_vld_i,
  output logic     cfg_rdy_o,
  output logic     cfg_err_o,
  output lmul_t    cfg_emul_o,
  // Vector lane
  input  data_t    lane_data_i,
  input  logic     lane_vld_i,
  output logic     lane_rdy_o,
  // Memory write side
  output logic     wr_start_o,
  output addr_t    wr_addr_o,
  output vl_t      wr_len_o,
  output data_t    wr_data_o,
  output logic     wr_tvalid_o,
  input  logic     wr_tready_i,
  output logic     wr_tlast_o,
  input  logic     wr_done_i,
  output logic     st_done_o
);

  logic     xfer_start;
  logic     xfer_done;
  st_mode_t mode;
  addr_t    base;
  stride_t  stride;
  vl_t      vl;
  logic     buf_wvld;
  logic     buf_wrdy;
  data_t    buf_wdata;
  logic     buf_rvld;
  logic     buf_rrdy;
  data_t    buf_rdata;

  ////////////////////
  // Input side
  ////////////////////

  st_cfg_capture i_st_cfg_capture (
    .clk          (clk),
    .rstn         (rstn),
    .cfg_sew_i    (cfg_sew_i),
    .cfg_eew_i    (cfg_eew_i),
    .cfg_lmul_i   (cfg_lmul_i),
    .cfg_mode_i   (cfg_mode_i),
    .cfg_base_i   (cfg_base_i),
    .cfg_stride_i (cfg_stride_i),
    .cfg_vl_i     (cfg_vl_i),
    .cfg_vld_i    (cfg_vld_i),
    .cfg_rdy_o    (cfg_rdy_o),
    .cfg_err_o    (cfg_err_o),
    .cfg_emul_o   (cfg_emul_o),
    .xfer_done_i  (xfer_done),
    .xfer_start_o (xfer_start),
    .mode_o       (mode),
    .base_o       (base),
    .stride_o     (stride),
    .vl_o         (vl)
  );

  ////////////////////
  // Lane to buffer
  ////////////////////

  st_lane_writer i_st_lane_writer (
    .clk          (clk),
    .rstn         (rstn),
    .xfer_start_i (xfer_start),
    .vl_i         (vl),
    .lane_data_i  (lane_data_i),
    .lane_vld_i   (lane_vld_i),
    .lane_rdy_o   (lane_rdy_o),
    .buf_wrdy_i   (buf_wrdy),
    .buf_wvld_o   (buf_wvld),
    .buf_wdata_o  (buf_wdata)
  );

  st_data_buffer i_st_data_buffer (
    .clk     (clk),
    .rstn    (rstn),
    .wvld_i  (buf_wvld),
    .wdata_i (buf_wdata),
    .wrdy_o  (buf_wrdy),
    .rrdy_i  (buf_rrdy),
    .rvld_o  (buf_rvld),
    .rdata_o (buf_rdata)
  );

  ////////////////////
  // Output side
  ////////////////////

  st_stream_writer i_st_stream_writer (
    .clk          (clk),
    .rstn         (rstn),
    .xfer_start_i (xfer_start),
    .mode_i       (mode),
    .base_i       (base),
    .stride_i     (stride),
    .vl_i         (vl),
    .buf_rvld_i   (buf_rvld),
    .buf_rdata_i  (buf_rdata),
    .buf_rrdy_o   (buf_rrdy),
    .wr_start_o   (wr_start_o),
    .wr_addr_o    (wr_addr_o),
    .wr_len_o     (wr_len_o),
    .wr_data_o    (wr_data_o),
    .wr_tvalid_o  (wr_tvalid_o),
    .wr_tready_i  (wr_tready_i),
    .wr_tlast_o   (wr_tlast_o),
    .wr_done_i    (wr_done_i),
    .xfer_done_o  (xfer_done),
    .st_done_o    (st_done_o)
  );

endmodule

/* st_stream_writer.sv */
// Write stream sequencer for unit-stride and strided stores
// Issues burst commands and drains the buffer head as stream beats
`timescale 1ns/1ps

module st_stream_writer
  import mcu_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  // Transfer fields from the configuration stage
  input  logic     xfer_start_i,
  input  st_mode_t mode_i,
  input  addr_t    base_i,
  input  stride_t  stride_i,
  input  vl_t      vl_i,
  // Store buffer read port
  input  logic     buf_rvld_i,
  input  data_t    buf_rdata_i,
  output logic     buf_rrdy_o,
  // Memory write side
  output logic     wr_start_o,
  output addr_t    wr_addr_o,
  output vl_t      wr_len_o,
  output data_t    wr_data_o,
  output logic     wr_tvalid_o,
  input  logic     wr_tready_i,
  output logic     wr_tlast_o,
  input  logic     wr_done_i,
  // Completion
  output logic     xfer_done_o,
  output logic     st_done_o
);

  wr_state_t state_q;
  wr_state_t state_d;
  addr_t     addr_q;
  vl_t       len_q;
  vl_t       beats_q;
  vl_t       bursts_q;
  logic      done_q;
  logic      beat_hs;
  logic      last_beat;
  logic      last_burst;
  logic      final_done;

  assign beat_hs    = (state_q == WR_BEATS) && buf_rvld_i && wr_tready_i;
  assign last_beat  = (beats_q == vl_t'(1));
  assign last_burst = (bursts_q == vl_t'(1));
  assign final_done = (state_q == WR_WAIT) && wr_done_i && last_burst;

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      WR_IDLE: begin
        if (xfer_start_i) begin
          state_d = WR_START;
        end
      end
      WR_START: begin
        state_d = WR_BEATS;
      end
      WR_BEATS: begin
        if (beat_hs && last_beat) begin
          state_d = WR_WAIT;
        end
      end
      WR_WAIT: begin
        if (wr_done_i) begin
          state_d = last_burst ? WR_IDLE : WR_START;
        end
      end
      default: begin
        state_d = WR_IDLE;
      end
    endcase
  end

  // Burst and beat counters
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q  <= WR_IDLE;
      beats_q  <= '0;
      bursts_q <= '0;
      done_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= final_done;
      case (state_q)
        WR_IDLE: begin
          if (xfer_start_i) begin
            // Unit-stride is one long burst, strided is vl single beats
            bursts_q <= (mode_i == ST_UNIT) ? vl_t'(1) : vl_i;
          end
        end
        WR_START: begin
          beats_q <= len_q;
        end
        WR_BEATS: begin
          if (beat_hs) begin
            beats_q <= beats_q - vl_t'(1);
          end
        end
        WR_WAIT: begin
          if (wr_done_i) begin
            bursts_q <= bursts_q - vl_t'(1);
          end
        end
        default: begin
          beats_q <= beats_q;
        end
      endcase
    end
  end

  ////////////////////
  // Burst address
  ////////////////////

  always_ff @(posedge clk) begin
    if ((state_q == WR_IDLE) && xfer_start_i) begin
      addr_q <= base_i;
      len_q  <= (mode_i == ST_UNIT) ? vl_i : vl_t'(1);
    end else if ((state_q == WR_WAIT) && wr_done_i) begin
      // Next strided element sits one stride further on
      addr_q <= addr_q + stride_i;
    end
  end

  assign wr_start_o  = (state_q == WR_START);
  assign wr_addr_o   = addr_q;
  assign wr_len_o    = len_q;
  // Beats come straight from the buffer head
  assign wr_data_o   = buf_rdata_i;
  assign wr_tvalid_o = (state_q == WR_BEATS) && buf_rvld_i;
  assign wr_tlast_o  = (state_q == WR_BEATS) && last_beat;
  assign buf_rrdy_o  = (state_q == WR_BEATS) && wr_tready_i;
  assign xfer_done_o = done_q;
  assign st_done_o   = done_q;

endmodule

/* st_data_buffer.sv */
// Store buffer of MAX_VL elements, circular with occupancy count
// Head element is held in a register for the stream side
`timescale 1ns/1ps

module st_data_buffer
  import mcu_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  // Write side
  input  logic  wvld_i,
  input  data_t wdata_i,
  output logic  wrdy_o,
  // Read side
  input  logic  rrdy_i,
  output logic  rvld_o,
  output data_t rdata_o
);

  data_t            mem [MAX_VL];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] rd_ptr_nxt;
  vl_t              cnt_q;
  vl_t              cnt_d;
  logic             push;
  logic             pop;
  logic             rvld_q;
  data_t            head_q;

  assign push       = wvld_i && wrdy_o;
  assign pop        = rvld_o && rrdy_i;
  // Pointers wrap on their own since MAX_VL is a power of two
  assign rd_ptr_nxt = rd_ptr_q + PTR_W'(1);

  always_comb begin
    cnt_d = cnt_q;
    if (push && !pop) begin
      cnt_d = cnt_q + vl_t'(1);
    end else if (pop && !push) begin
      cnt_d = cnt_q - vl_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      rvld_q   <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_nxt;
      end
      cnt_q  <= cnt_d;
      rvld_q <= (cnt_d != '0);
    end
  end

  ////////////////////
  // Storage and head
  ////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= wdata_i;
    end
    // Head follows mem[rd_ptr], bypassing a write into an emptying buffer
    if (pop) begin
      head_q <= (cnt_q == vl_t'(1)) ? wdata_i : mem[rd_ptr_nxt];
    end else if (cnt_q == '0) begin
      head_q <= wdata_i;
    end
  end

  assign wrdy_o  = (cnt_q != vl_t'(MAX_VL));
  assign rvld_o  = rvld_q;
  assign rdata_o = head_q;

endmodule

/* st_lane_writer.sv */
// Lane side writer feeding the store buffer
// Counts the elements still owed by the vector lane
`timescale 1ns/1ps

module st_lane_writer
  import mcu_pkg::*;
(
  input  logic  clk,
  input  logic  rstn,
  // From the configuration stage
  input  logic  xfer_start_i,
  input  vl_t   vl_i,
  // Vector lane handshake
  input  data_t lane_data_i,
  input  logic  lane_vld_i,
  output logic  lane_rdy_o,
  // Store buffer write port
  input  logic  buf_wrdy_i,
  output logic  buf_wvld_o,
  output data_t buf_wdata_o
);

  vl_t  remain_q;
  logic active;
  logic lane_hs;

  ////////////////////
  // Element counter
  ////////////////////

  // Elements still to be taken from the lane for this store
  assign active  = (remain_q != '0);
  assign lane_hs = lane_vld_i && lane_rdy_o;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      remain_q <= '0;
    end else if (xfer_start_i) begin
      remain_q <= vl_i;
    end else if (lane_hs) begin
      remain_q <= remain_q - vl_t'(1);
    end
  end

  ////////////////////
  // Handshake path
  ////////////////////

  // Lane transfer and buffer write happen in the same cycle
  assign lane_rdy_o  = active && buf_wrdy_i;
  assign buf_wvld_o  = active && lane_vld_i;
  assign buf_wdata_o = lane_data_i;

endmodule

/* st_cfg_capture.sv */
// Store configuration stage with scheduler handshake
// Legality check, EMUL result and the registered transfer fields
`timescale 1ns/1ps

module st_cfg_capture
  import mcu_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  // Scheduler side
  input  sew_t     cfg_sew_i,
  input  sew_t     cfg_eew_i,
  input  lmul_t    cfg_lmul_i,
  input  st_mode_t cfg_mode_i,
  input  addr_t    cfg_base_i,
  input  stride_t  cfg_stride_i,
  input  vl_t      cfg_vl_i,
  input  logic     cfg_vld_i,
  output logic     cfg_rdy_o,
  output logic     cfg_err_o,
  output lmul_t    cfg_emul_o,
  // Towards the lane writer and the stream sequencer
  input  logic     xfer_done_i,
  output logic     xfer_start_o,
  output st_mode_t mode_o,
  output addr_t    base_o,
  output stride_t  stride_o,
  output vl_t      vl_o
);

  cfg_state_t state_q;
  cfg_state_t state_d;
  emul_res_t  emul_res;
  logic       cfg_ok;
  logic       accept;
  logic       start_q;
  lmul_t      emul_q;
  st_mode_t   mode_q;
  addr_t      base_q;
  stride_t    stride_q;
  vl_t        vl_q;

  assign emul_res = emul_of(cfg_lmul_i, cfg_sew_i, cfg_eew_i);
  assign cfg_ok   = emul_res[3] && (cfg_vl_i != '0) && (cfg_vl_i <= vl_t'(MAX_VL));

  // Ready comes back already in the cycle the sequencer reports done
  assign cfg_rdy_o = (state_q == CFG_IDLE) || ((state_q == CFG_BUSY) && xfer_done_i);
  assign accept    = cfg_vld_i && cfg_rdy_o;

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    if (accept) begin
      state_d = cfg_ok ? CFG_BUSY : CFG_ERR;
    end else begin
      case (state_q)
        CFG_ERR: begin
          state_d = CFG_IDLE;
        end
        CFG_BUSY: begin
          if (xfer_done_i) begin
            state_d = CFG_IDLE;
          end
        end
        default: begin
          state_d = state_q;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= CFG_IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= accept && cfg_ok;
    end
  end

  ////////////////////
  // Captured fields
  ////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      emul_q   <= emul_res[2:0];
      mode_q   <= cfg_mode_i;
      base_q   <= cfg_base_i;
      stride_q <= cfg_stride_i;
      vl_q     <= cfg_vl_i;
    end
  end

  // Error is a one cycle pulse since CFG_ERR always returns to idle
  assign cfg_err_o    = (state_q == CFG_ERR);
  assign cfg_emul_o   = emul_q;
  assign xfer_start_o = start_q;
  assign mode_o       = mode_q;
  assign base_o       = base_q;
  assign stride_o     = stride_q;
  assign vl_o         = vl_q;

endmodule

/* mcu_pkg.sv */
// Shared widths, limits and types of the vector store unit
// Mode and state enums, EMUL rule for the configuration stage
package mcu_pkg;

  ////////////////////
  // Limits and widths
  ////////////////////

  // Largest vector the store buffer holds, a power of two
  localparam int MAX_VL = 16;
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  // Enough bits to count up to MAX_VL inclusive
  localparam int VL_W   = $clog2(MAX_VL + 1);
  localparam int PTR_W  = $clog2(MAX_VL);

  // Reserved encodings
  localparam logic [2:0] SEW_RSVD  = 3'd3;
  localparam logic [2:0] LMUL_RSVD = 3'd4;

  ////////////////////
  // Types
  ////////////////////

  // log2 of the element size in bytes
  typedef logic [2:0]        sew_t;
  // Signed log2 LMUL, 5..7 are the fractional settings
  typedef logic [2:0]        lmul_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [ADDR_W-1:0] stride_t;
  typedef logic [VL_W-1:0]   vl_t;
  typedef logic [DATA_W-1:0] data_t;
  // Bit 3 is the legal flag, bits 2:0 the EMUL code
  typedef logic [3:0]        emul_res_t;

  typedef enum logic {
    ST_UNIT,
    ST_STRIDED
  } st_mode_t;

  typedef enum logic [1:0] {
    CFG_IDLE,
    CFG_ERR,
    CFG_BUSY
  } cfg_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_START,
    WR_BEATS,
    WR_WAIT
  } wr_state_t;

  ////////////////////
  // EMUL rule
  ////////////////////

  // EMUL = LMUL + EEW - SEW in log2, legal only inside 1/8 .. 8
  function automatic emul_res_t emul_of(lmul_t lmul, sew_t sew, sew_t eew);
    int   sum;
    logic legal;
    sum   = int'($signed(lmul)) + int'(eew) - int'(sew);
    legal = (lmul != LMUL_RSVD) && (sew != SEW_RSVD) && (eew != SEW_RSVD) &&
            (sum >= -3) && (sum <= 3);
    // Low three bits of the sum give the lmul_t encoding back
    return {legal, 3'(sum)};
  endfunction

endpackage
